//--- bench/branch_core_tb.sv
`timescale 1ns/1ns

module branch_core_tb;

   localparam int N_ADDI     = 16;
   localparam int BR_LEN     = 24;
   localparam int BR_STEPS   = 40;
   localparam int JUMP_STEPS = 8;
   localparam int N_PROGS    = 3;
   localparam int PROG_LEN   = 64;
   localparam int PROG_STEPS = 300;
   localparam int PEND_STEPS = 5;
   localparam int STOP_STEPS = 40;
   localparam int LOADS      = core_cfg_pkg::IMEM_DEPTH + 1 + 31 * (2 + N_PROGS) + 3
                               + N_ADDI + BR_LEN + 1 + 7 + N_PROGS * PROG_LEN;
   localparam int STEPS      = PEND_STEPS + N_ADDI + BR_STEPS + JUMP_STEPS
                               + N_PROGS * PROG_STEPS + STOP_STEPS;
   localparam int TIMEOUT_CYCLES = STEPS + 4 * LOADS + 200;

   logic                       i_clock;
   logic                       i_reset;
   logic                       i_run;
   logic                       i_load_req;
   core_cfg_pkg::load_target_e i_load_target;
   core_cfg_pkg::addr_t        i_load_addr;
   core_cfg_pkg::word_t        i_load_data;
   logic                       o_load_ack;
   core_cfg_pkg::addr_t        o_pc;
   logic                       o_pc_valid;
   logic                       o_taken;
   logic                       o_wb_valid;
   core_cfg_pkg::reg_idx_t     o_wb_idx;
   core_cfg_pkg::word_t        o_wb_data;

   // Reference model state.
   core_cfg_pkg::word_t    ref_imem [core_cfg_pkg::IMEM_DEPTH];
   core_cfg_pkg::word_t    ref_regs [32];
   core_cfg_pkg::addr_t    ref_pc;
   core_cfg_pkg::addr_t    exp_pc;
   logic                   exp_taken;
   core_cfg_pkg::reg_idx_t exp_wb_idx;  // Zero means no write expected.
   core_cfg_pkg::word_t    exp_wb_data;

   integer seed;
   int     checks = 0;
   int     errors = 0;
   int     base_errors = 0;
   int     cycles = 0;

   branch_core_top i_branch_core_top (
      .i_clock(i_clock), .i_reset(i_reset), .i_run(i_run), .i_load_req(i_load_req),
      .i_load_target(i_load_target), .i_load_addr(i_load_addr), .i_load_data(i_load_data),
      .o_load_ack(o_load_ack), .o_pc(o_pc), .o_pc_valid(o_pc_valid), .o_taken(o_taken),
      .o_wb_valid(o_wb_valid), .o_wb_idx(o_wb_idx), .o_wb_data(o_wb_data)
   );

   always #4 i_clock = ~i_clock;

   always @(posedge i_clock)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("timeout, test did not finish");
         $display("Something failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Compare tasks.
   //////////////////////////////////////////////////////////////////////
   task automatic report_fail(string msg);
      errors++;
      $display("FAIL at %0t ns: %s", $time, msg);
   endtask

   task automatic check_pc(core_cfg_pkg::addr_t exp);
      checks++;
      if (o_pc_valid !== 1'b1 || o_pc !== exp)
         report_fail($sformatf("pc %0d valid %b, expected %0d", o_pc, o_pc_valid, exp));
   endtask

   task automatic check_taken(logic exp);
      checks++;
      if (o_taken !== exp)
         report_fail($sformatf("taken %b at pc %0d, expected %b", o_taken, o_pc, exp));
   endtask

   task automatic check_wb(core_cfg_pkg::reg_idx_t idx, core_cfg_pkg::word_t data);
      checks++;
      if (idx == '0)
      begin
         if (o_wb_valid !== 1'b0)
            report_fail($sformatf("unexpected write of %h to r%0d", o_wb_data, o_wb_idx));
      end
      else if (o_wb_valid !== 1'b1 || o_wb_idx !== idx || o_wb_data !== data)
         report_fail($sformatf("write r%0d=%h valid %b, expected r%0d=%h",
                               o_wb_idx, o_wb_data, o_wb_valid, idx, data));
   endtask

   task automatic end_test(string name);
      $display("test %s done, %0d errors", name, errors - base_errors);
      base_errors = errors;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Loader driver. Called and left 1 ns after a rising edge.
   //////////////////////////////////////////////////////////////////////
   task automatic finish_handshake(int hold);
      int waited;
      waited = 0;
      while (o_load_ack !== 1'b1 && waited < 4)
      begin
         @(posedge i_clock);
         #1;
         waited++;
      end
      if (o_load_ack !== 1'b1)
      begin
         errors++;
         $display("no acknowledge for load at address %0d", i_load_addr);
      end
      repeat (hold)
      begin
         @(posedge i_clock);
         #1;
         if (o_load_ack !== 1'b1)
            report_fail("ack fell while req was high");
      end
      i_load_req = 1'b0;
      @(posedge i_clock);
      #1;
      if (o_load_ack !== 1'b0)
         report_fail("ack still high after req fell");
   endtask

   task automatic load_word(core_cfg_pkg::load_target_e target, core_cfg_pkg::addr_t addr,
                            core_cfg_pkg::word_t data);
      i_load_target = target;
      i_load_addr   = addr;
      i_load_data   = data;
      i_load_req    = 1'b1;
      if (target == core_cfg_pkg::IMEM)
         ref_imem[addr] = data;
      else if (addr[4:0] != 5'd0)
         ref_regs[addr[4:0]] = data;  // r0 stays zero.
      finish_handshake(0);
   endtask

   task automatic load_random_regs(core_cfg_pkg::word_t mask);
      for (int r = 1; r < 32; r++)
         load_word(core_cfg_pkg::REGS, core_cfg_pkg::addr_t'(r), $random(seed) & mask);
   endtask

   function automatic core_cfg_pkg::word_t random_instr();
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
      logic [25:0] idx;
      rs  = 5'($random(seed));
      rt  = 5'($random(seed));
      imm = 16'($random(seed) % 7);  // Short hops both ways.
      idx = 26'($unsigned($random(seed)) % PROG_LEN);
      case ($unsigned($random(seed)) % 8)
         0: return {mips_isa_pkg::OP_J, idx};
         1: return {mips_isa_pkg::OP_JAL, idx};
         2: return {mips_isa_pkg::OP_BEQ, rs, rt, imm};
         3: return {mips_isa_pkg::OP_BNE, rs, rt, imm};
         4: return {mips_isa_pkg::OP_SPECIAL, rs, 15'd0, mips_isa_pkg::FUNCT_JR};
         5: return {mips_isa_pkg::OP_SPECIAL, rs, 5'd0, rt, 5'd0, mips_isa_pkg::FUNCT_JALR};
         6: return {6'b100011, rs, rt, imm};  // LW acts as a no-op here.
         default: return {mips_isa_pkg::OP_ADDI, rs, rt, 16'($random(seed) % 16)};
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Reference model, one instruction per call.
   //////////////////////////////////////////////////////////////////////
   task automatic step_model();
      core_cfg_pkg::word_t w;
      core_cfg_pkg::word_t a;
      core_cfg_pkg::word_t b;
      core_cfg_pkg::addr_t pc1;
      core_cfg_pkg::addr_t next;
      w           = ref_imem[ref_pc];
      a           = ref_regs[w[25:21]];
      b           = ref_regs[w[20:16]];
      pc1         = ref_pc + 1'b1;
      next        = pc1;
      exp_pc      = ref_pc;
      exp_taken   = 1'b0;
      exp_wb_idx  = '0;
      exp_wb_data = '0;
      case (w[31:26])
         mips_isa_pkg::OP_SPECIAL:
         begin
            if (w[5:0] == mips_isa_pkg::FUNCT_JR || w[5:0] == mips_isa_pkg::FUNCT_JALR)
            begin
               exp_taken = 1'b1;
               next      = a[10:0];
               if (w[5:0] == mips_isa_pkg::FUNCT_JALR)
               begin
                  exp_wb_idx  = w[15:11];  // rd of 0 means no write.
                  exp_wb_data = 32'(pc1);
               end
            end
         end
         mips_isa_pkg::OP_J,
         mips_isa_pkg::OP_JAL:
         begin
            exp_taken = 1'b1;
            next      = w[10:0];
            if (w[31:26] == mips_isa_pkg::OP_JAL)
            begin
               exp_wb_idx  = 5'd31;
               exp_wb_data = 32'(pc1);
            end
         end
         mips_isa_pkg::OP_BEQ:
         begin
            exp_taken = (a == b);
            if (exp_taken)
               next = pc1 + w[10:0];  // Wraps at 2048.
         end
         mips_isa_pkg::OP_BNE:
         begin
            exp_taken = (a != b);
            if (exp_taken)
               next = pc1 + w[10:0];
         end
         mips_isa_pkg::OP_ADDI:
         begin
            exp_wb_idx  = w[20:16];
            exp_wb_data = a + {{16{w[15]}}, w[15:0]};
         end
         default: ;
      endcase
      if (exp_wb_idx != '0)
         ref_regs[exp_wb_idx] = exp_wb_data;
      ref_pc = next;
   endtask

   task automatic start_run();
      i_run  = 1'b1;
      ref_pc = '0;
      @(posedge i_clock);
      #1;
   endtask

   task automatic step_check(int n);
      repeat (n)
      begin
         @(negedge i_clock);  // Outputs have settled by mid-cycle.
         step_model();
         check_pc(exp_pc);
         check_taken(exp_taken);
         check_wb(exp_wb_idx, exp_wb_data);
         @(posedge i_clock);
         #1;
      end
   endtask

   task automatic stop_run();
      i_run = 1'b0;
      @(posedge i_clock);
      #1;
      if (o_pc_valid !== 1'b0 || o_pc !== '0)
         report_fail("core did not stop at PC 0");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence.
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      seed          = 32'h886b;
      i_clock       = 1'b0;
      i_reset       = 1'b1;
      i_run         = 1'b0;
      i_load_req    = 1'b0;
      i_load_target = core_cfg_pkg::IMEM;
      i_load_addr   = '0;
      i_load_data   = '0;
      for (int r = 0; r < 32; r++)
         ref_regs[r] = '0;
      repeat (8) @(posedge i_clock);
      #1;
      i_reset = 1'b0;

      // Handshake with a request held off by a running core.
      if (o_load_ack !== 1'b0)
         report_fail("ack high after reset");
      for (int a = 0; a < core_cfg_pkg::IMEM_DEPTH; a++)
         load_word(core_cfg_pkg::IMEM, core_cfg_pkg::addr_t'(a),
                   {6'b100011, 15'd0, core_cfg_pkg::addr_t'(a)});  // No-op tagged by address.
      i_run = 1'b1;
      @(posedge i_clock);
      #1;
      i_load_target = core_cfg_pkg::IMEM;
      i_load_addr   = 11'd45;  // The jump test ends here.
      i_load_data   = {mips_isa_pkg::OP_ADDI, 5'd0, 5'd4, 16'h5a5a};
      i_load_req    = 1'b1;
      repeat (PEND_STEPS)
      begin
         @(posedge i_clock);
         #1;
         if (o_load_ack !== 1'b0)
            report_fail("ack given while running");
      end
      i_run = 1'b0;
      finish_handshake(2);
      ref_imem[45] = {mips_isa_pkg::OP_ADDI, 5'd0, 5'd4, 16'h5a5a};
      end_test("handshake");

      load_random_regs(32'hffff_ffff);
      for (int i = 0; i < N_ADDI; i++)
         load_word(core_cfg_pkg::IMEM, core_cfg_pkg::addr_t'(i), {mips_isa_pkg::OP_ADDI,
                   5'($random(seed)), 5'($random(seed)), 16'($random(seed))});
      start_run();
      step_check(N_ADDI);
      stop_run();
      end_test("addi_sequence");

      load_random_regs(32'h3);  // Few distinct values make rs and rt match often.
      load_word(core_cfg_pkg::IMEM, 11'd0, {mips_isa_pkg::OP_BEQ, 10'd0, 16'hfff7});
      load_word(core_cfg_pkg::IMEM, 11'd2040, {mips_isa_pkg::OP_BEQ, 10'd0, 16'd20});
      for (int i = 1; i < BR_LEN; i++)
         load_word(core_cfg_pkg::IMEM, core_cfg_pkg::addr_t'(i),
                   {($random(seed) & 1) ? mips_isa_pkg::OP_BNE : mips_isa_pkg::OP_BEQ,
                    5'($unsigned($random(seed)) % 8), 5'($unsigned($random(seed)) % 8),
                    16'($random(seed) % 7)});
      start_run();
      step_check(BR_STEPS);
      stop_run();
      end_test("beq_bne");

      load_word(core_cfg_pkg::REGS, 11'd2, 32'hffff_f814);  // Low bits give 20.
      load_word(core_cfg_pkg::REGS, 11'd3, 32'd30);
      load_word(core_cfg_pkg::REGS, 11'd9, 32'd0);
      load_word(core_cfg_pkg::IMEM, 11'd0, {mips_isa_pkg::OP_JAL, 26'h2aa_a80a});
      load_word(core_cfg_pkg::IMEM, 11'd10,
                {mips_isa_pkg::OP_SPECIAL, 5'd2, 5'd0, 5'd7, 5'd0, mips_isa_pkg::FUNCT_JALR});
      load_word(core_cfg_pkg::IMEM, 11'd20,
                {mips_isa_pkg::OP_SPECIAL, 5'd3, 5'd0, 5'd0, 5'd0, mips_isa_pkg::FUNCT_JALR});
      load_word(core_cfg_pkg::IMEM, 11'd30, {mips_isa_pkg::OP_BEQ, 5'd0, 5'd9, 16'd5});
      load_word(core_cfg_pkg::IMEM, 11'd36, {mips_isa_pkg::OP_J, 26'd40});
      load_word(core_cfg_pkg::IMEM, 11'd40,
                {mips_isa_pkg::OP_SPECIAL, 5'd31, 15'd0, mips_isa_pkg::FUNCT_JR});
      load_word(core_cfg_pkg::IMEM, 11'd1, {mips_isa_pkg::OP_J, 26'd45});
      start_run();
      step_check(JUMP_STEPS);
      stop_run();
      end_test("jumps_and_links");

      for (int p = 0; p < N_PROGS; p++)
      begin
         load_random_regs(32'h1f);  // Register jumps stay inside the program.
         for (int i = 0; i < PROG_LEN; i++)
            load_word(core_cfg_pkg::IMEM, core_cfg_pkg::addr_t'(i), random_instr());
         start_run();
         step_check(PROG_STEPS);
         stop_run();
      end
      end_test("random_programs");

      start_run();
      step_check(15);
      stop_run();
      start_run();
      step_check(10);
      i_reset = 1'b1;
      @(posedge i_clock);
      #1;
      if (o_pc_valid !== 1'b0 || o_pc !== '0)
         report_fail("core kept running through reset");
      i_reset = 1'b0;
      for (int r = 0; r < 32; r++)
         ref_regs[r] = '0;
      ref_pc = '0;
      @(posedge i_clock);
      #1;
      step_check(15);
      stop_run();
      end_test("stop_and_reset");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

//--- files.f
hdl/core_cfg_pkg.sv
hdl/mips_isa_pkg.sv
hdl/instruction_memory.sv
hdl/register_file.sv
hdl/branch_control_decoder.sv
hdl/branch_address_calculator.sv
hdl/program_loader.sv
hdl/fetch_unit.sv
hdl/branch_core_top.sv
bench/branch_core_tb.sv

//--- hdl/branch_address_calculator.sv
`timescale 1ns/1ns

module branch_address_calculator
(
   input  mips_isa_pkg::branch_kind_e       i_branch_kind,
   input  core_cfg_pkg::addr_t              i_pc_plus_one,
   input  logic [mips_isa_pkg::IMM_W-1:0]   i_immediate,
   input  logic [mips_isa_pkg::INDEX_W-1:0] i_index,
   input  core_cfg_pkg::word_t              i_rs_data,
   input  core_cfg_pkg::word_t              i_rt_data,
   output logic                             o_taken,
   output core_cfg_pkg::addr_t              o_target
);

   core_cfg_pkg::addr_t branch_sum;

   // Offset is in words, so no shift. Wraps modulo the address space.
   assign branch_sum = i_pc_plus_one + i_immediate[core_cfg_pkg::ADDR_W-1:0];

   always_comb
   begin
      o_taken  = 1'b0;
      o_target = i_pc_plus_one;
      case (i_branch_kind)
         mips_isa_pkg::BR_JR,
         mips_isa_pkg::BR_JALR:
         begin
            o_taken  = 1'b1;
            o_target = i_rs_data[core_cfg_pkg::ADDR_W-1:0];
         end
         mips_isa_pkg::BR_BEQ:
         begin
            o_taken  = (i_rs_data == i_rt_data);
            o_target = branch_sum;
         end
         mips_isa_pkg::BR_BNE:
         begin
            o_taken  = (i_rs_data != i_rt_data);
            o_target = branch_sum;
         end
         mips_isa_pkg::BR_JUMP:
         begin
            o_taken  = 1'b1;
            o_target = i_index[core_cfg_pkg::ADDR_W-1:0];  // Upper index bits unused.
         end
         default: ;  // Not a branch.
      endcase
   end

endmodule

//--- hdl/branch_control_decoder.sv
`timescale 1ns/1ns

module branch_control_decoder
(
   input  core_cfg_pkg::word_t                i_instruction,
   input  core_cfg_pkg::addr_t                i_pc_plus_one,
   input  core_cfg_pkg::word_t                i_rs_data,
   output core_cfg_pkg::reg_idx_t             o_rs,
   output core_cfg_pkg::reg_idx_t             o_rt,
   output mips_isa_pkg::branch_kind_e         o_branch_kind,
   output logic [mips_isa_pkg::IMM_W-1:0]     o_immediate,
   output logic [mips_isa_pkg::INDEX_W-1:0]   o_index,
   output logic                               o_wb_en,
   output core_cfg_pkg::reg_idx_t             o_wb_idx,
   output core_cfg_pkg::word_t                o_wb_data
);

   logic [mips_isa_pkg::OPCODE_MSB-mips_isa_pkg::OPCODE_LSB:0] opcode;
   logic [mips_isa_pkg::FUNCT_MSB-mips_isa_pkg::FUNCT_LSB:0]   funct;
   core_cfg_pkg::reg_idx_t rd;
   core_cfg_pkg::word_t    link_value;
   core_cfg_pkg::word_t    addi_sum;
   logic                   wb_request;
   logic                   wb_link;  // High selects the link value.

   //////////////////////////////////////////////////////////////////////
   // Field split.
   //////////////////////////////////////////////////////////////////////
   assign opcode      = i_instruction[mips_isa_pkg::OPCODE_MSB:mips_isa_pkg::OPCODE_LSB];
   assign funct       = i_instruction[mips_isa_pkg::FUNCT_MSB:mips_isa_pkg::FUNCT_LSB];
   assign o_rs        = i_instruction[mips_isa_pkg::RS_MSB:mips_isa_pkg::RS_LSB];
   assign o_rt        = i_instruction[mips_isa_pkg::RT_MSB:mips_isa_pkg::RT_LSB];
   assign rd          = i_instruction[mips_isa_pkg::RD_MSB:mips_isa_pkg::RD_LSB];
   assign o_immediate = i_instruction[mips_isa_pkg::IMM_W-1:0];
   assign o_index     = i_instruction[mips_isa_pkg::INDEX_W-1:0];

   // Return address, zero extended to a full word.
   assign link_value = {{(core_cfg_pkg::DATA_W-core_cfg_pkg::ADDR_W){1'b0}}, i_pc_plus_one};
   assign addi_sum   = i_rs_data +
      {{(core_cfg_pkg::DATA_W-mips_isa_pkg::IMM_W){o_immediate[mips_isa_pkg::IMM_W-1]}},
       o_immediate};

   always_comb
   begin
      o_branch_kind = mips_isa_pkg::BR_NONE;
      wb_request    = 1'b0;
      wb_link       = 1'b0;
      o_wb_idx      = o_rt;
      case (opcode)
         mips_isa_pkg::OP_SPECIAL:
         begin
            case (funct)
               mips_isa_pkg::FUNCT_JR:
                  o_branch_kind = mips_isa_pkg::BR_JR;
               mips_isa_pkg::FUNCT_JALR:
               begin
                  o_branch_kind = mips_isa_pkg::BR_JALR;
                  wb_request    = 1'b1;
                  wb_link       = 1'b1;
                  o_wb_idx      = rd;
               end
               default: ;  // Other R-type ops are no-ops here.
            endcase
         end
         mips_isa_pkg::OP_J:
            o_branch_kind = mips_isa_pkg::BR_JUMP;
         mips_isa_pkg::OP_JAL:
         begin
            o_branch_kind = mips_isa_pkg::BR_JUMP;
            wb_request    = 1'b1;
            wb_link       = 1'b1;
            o_wb_idx      = core_cfg_pkg::reg_idx_t'(core_cfg_pkg::LINK_REG);
         end
         mips_isa_pkg::OP_BEQ: o_branch_kind = mips_isa_pkg::BR_BEQ;
         mips_isa_pkg::OP_BNE: o_branch_kind = mips_isa_pkg::BR_BNE;
         mips_isa_pkg::OP_ADDI:
            wb_request = 1'b1;  // Result goes to rt.
         default: ;
      endcase
   end

   assign o_wb_en   = wb_request && (o_wb_idx != '0);  // Drop writes to register 0.
   assign o_wb_data = wb_link ? link_value : addi_sum;

endmodule

//--- hdl/branch_core_top.sv
`timescale 1ns/1ns

module branch_core_top
(
   input  logic                       i_clock,
   input  logic                       i_reset,
   input  logic                       i_run,
   input  logic                       i_load_req,
   input  core_cfg_pkg::load_target_e i_load_target,
   input  core_cfg_pkg::addr_t        i_load_addr,
   input  core_cfg_pkg::word_t        i_load_data,
   output logic                       o_load_ack,
   output core_cfg_pkg::addr_t        o_pc,
   output logic                       o_pc_valid,
   output logic                       o_taken,
   output logic                       o_wb_valid,
   output core_cfg_pkg::reg_idx_t     o_wb_idx,
   output core_cfg_pkg::word_t        o_wb_data
);

   logic                             imem_wr_en;
   logic                             reg_wr_en;
   core_cfg_pkg::addr_t              wr_addr;
   core_cfg_pkg::word_t              wr_data;
   core_cfg_pkg::addr_t              pc_plus_one;
   core_cfg_pkg::word_t              instruction;
   core_cfg_pkg::reg_idx_t           rs;
   core_cfg_pkg::reg_idx_t           rt;
   core_cfg_pkg::word_t              rs_data;
   core_cfg_pkg::word_t              rt_data;
   mips_isa_pkg::branch_kind_e       branch_kind;
   logic [mips_isa_pkg::IMM_W-1:0]   immediate;
   logic [mips_isa_pkg::INDEX_W-1:0] index;
   logic                             wb_en;
   logic                             taken;
   core_cfg_pkg::addr_t              target;
   logic                             exec;

   assign exec       = o_pc_valid & i_run;  // An instruction retires this cycle.
   assign o_wb_valid = wb_en & exec;
   assign o_taken    = taken & exec;

   program_loader u_program_loader (
      .i_clock(i_clock), .i_reset(i_reset), .i_run(i_run),
      .i_load_req(i_load_req), .i_load_target(i_load_target),
      .i_load_addr(i_load_addr), .i_load_data(i_load_data),
      .o_load_ack(o_load_ack), .o_imem_wr_en(imem_wr_en), .o_reg_wr_en(reg_wr_en),
      .o_wr_addr(wr_addr), .o_wr_data(wr_data)
   );

   instruction_memory u_instruction_memory (
      .i_clock(i_clock), .i_wr_en(imem_wr_en), .i_wr_addr(wr_addr),
      .i_wr_data(wr_data), .i_rd_addr(o_pc), .o_rd_data(instruction)
   );

   register_file u_register_file (
      .i_clock(i_clock), .i_reset(i_reset), .i_rs(rs), .i_rt(rt),
      .i_load_en(reg_wr_en), .i_load_idx(wr_addr[core_cfg_pkg::REG_IDX_W-1:0]),
      .i_load_data(wr_data), .i_wb_en(o_wb_valid), .i_wb_idx(o_wb_idx),
      .i_wb_data(o_wb_data), .o_rs_data(rs_data), .o_rt_data(rt_data)
   );

   branch_control_decoder u_branch_control_decoder (
      .i_instruction(instruction), .i_pc_plus_one(pc_plus_one), .i_rs_data(rs_data),
      .o_rs(rs), .o_rt(rt), .o_branch_kind(branch_kind), .o_immediate(immediate),
      .o_index(index), .o_wb_en(wb_en), .o_wb_idx(o_wb_idx), .o_wb_data(o_wb_data)
   );

   branch_address_calculator u_branch_address_calculator (
      .i_branch_kind(branch_kind), .i_pc_plus_one(pc_plus_one), .i_immediate(immediate),
      .i_index(index), .i_rs_data(rs_data), .i_rt_data(rt_data),
      .o_taken(taken), .o_target(target)
   );

   fetch_unit u_fetch_unit (
      .i_clock(i_clock), .i_reset(i_reset), .i_run(i_run), .i_taken(taken),
      .i_target(target), .o_pc(o_pc), .o_pc_plus_one(pc_plus_one),
      .o_pc_valid(o_pc_valid)
   );

endmodule

//--- hdl/core_cfg_pkg.sv
package core_cfg_pkg;

   localparam int ADDR_W     = 11;    // PC counts words, not bytes.
   localparam int DATA_W     = 32;
   localparam int REG_IDX_W  = 5;
   localparam int IMEM_DEPTH = 2048;
   localparam int LINK_REG   = 31;    // Written by JAL.

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [DATA_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // Where a loader transaction goes.
   typedef enum logic {
      IMEM = 1'b0,
      REGS = 1'b1
   } load_target_e;

endpackage

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
(
   input  logic                i_clock,
   input  logic                i_reset,
   input  logic                i_run,
   input  logic                i_taken,
   input  core_cfg_pkg::addr_t i_target,
   output core_cfg_pkg::addr_t o_pc,
   output core_cfg_pkg::addr_t o_pc_plus_one,
   output logic                o_pc_valid
);

   core_cfg_pkg::addr_t next_pc;

   assign o_pc_plus_one = o_pc + 1'b1;
   assign next_pc       = i_taken ? i_target : o_pc_plus_one;

   //////////////////////////////////////////////////////////////////////
   // PC and run control.
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_pc       <= '0;
         o_pc_valid <= 1'b0;
      end
      else
      begin
         o_pc_valid <= i_run;
         if (!i_run)
            o_pc <= '0;  // Stopped, restart from 0.
         else if (o_pc_valid)
            o_pc <= next_pc;
      end
   end

endmodule

//--- hdl/instruction_memory.sv
`timescale 1ns/1ns

module instruction_memory
(
   input  logic                i_clock,
   input  logic                i_wr_en,
   input  core_cfg_pkg::addr_t i_wr_addr,
   input  core_cfg_pkg::word_t i_wr_data,
   input  core_cfg_pkg::addr_t i_rd_addr,
   output core_cfg_pkg::word_t o_rd_data
);

   core_cfg_pkg::word_t mem [core_cfg_pkg::IMEM_DEPTH];

   // Loader side.
   always_ff @(posedge i_clock)
   begin
      if (i_wr_en)
         mem[i_wr_addr] <= i_wr_data;
   end

   assign o_rd_data = mem[i_rd_addr];  // Fetch reads in the same cycle.

endmodule

//--- hdl/mips_isa_pkg.sv
package mips_isa_pkg;

   //////////////////////////////////////////////////////////////////////
   // Instruction field positions.
   //////////////////////////////////////////////////////////////////////
   localparam int OPCODE_MSB = 31;
   localparam int OPCODE_LSB = 26;
   localparam int RS_MSB     = 25;
   localparam int RS_LSB     = 21;
   localparam int RT_MSB     = 20;
   localparam int RT_LSB     = 16;
   localparam int RD_MSB     = 15;
   localparam int RD_LSB     = 11;
   localparam int FUNCT_MSB  = 5;
   localparam int FUNCT_LSB  = 0;
   localparam int IMM_W      = 16;  // Immediate occupies [15:0].
   localparam int INDEX_W    = 26;  // Jump index occupies [25:0].

   //////////////////////////////////////////////////////////////////////
   // Encodings.
   //////////////////////////////////////////////////////////////////////
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'b000000,  // R-type, look at funct.
      OP_J       = 6'b000010,
      OP_JAL     = 6'b000011,
      OP_BEQ     = 6'b000100,
      OP_BNE     = 6'b000101,
      OP_ADDI    = 6'b001000
   } opcode_e;

   typedef enum logic [5:0] {
      FUNCT_JR   = 6'b001000,
      FUNCT_JALR = 6'b001001
   } funct_e;

   // Kind of control transfer handed to the address calculator.
   typedef enum logic [2:0] {
      BR_NONE = 3'd0,
      BR_JR   = 3'd1,
      BR_JALR = 3'd2,
      BR_BEQ  = 3'd3,
      BR_BNE  = 3'd4,
      BR_JUMP = 3'd5  // J and JAL.
   } branch_kind_e;

endpackage

//--- hdl/program_loader.sv
`timescale 1ns/1ns

module program_loader
(
   input  logic                       i_clock,
   input  logic                       i_reset,
   input  logic                       i_run,
   input  logic                       i_load_req,
   input  core_cfg_pkg::load_target_e i_load_target,
   input  core_cfg_pkg::addr_t        i_load_addr,
   input  core_cfg_pkg::word_t        i_load_data,
   output logic                       o_load_ack,
   output logic                       o_imem_wr_en,
   output logic                       o_reg_wr_en,
   output core_cfg_pkg::addr_t        o_wr_addr,
   output core_cfg_pkg::word_t        o_wr_data
);

   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      WAIT_RELEASE
   } state_e;

   state_e                     state;
   core_cfg_pkg::load_target_e target_q;
   logic                       accept;

   // A request waits here while the core runs.
   assign accept = (state == IDLE) && i_load_req && !i_run;

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
         state <= IDLE;
      else
      begin
         case (state)
            IDLE:         if (accept) state <= WRITE;
            WRITE:        state <= WAIT_RELEASE;  // One write strobe.
            WAIT_RELEASE: if (!i_load_req) state <= IDLE;
            default:      state <= IDLE;
         endcase
      end
   end

   // Capture the transaction.
   always_ff @(posedge i_clock)
   begin
      if (accept)
      begin
         target_q  <= i_load_target;
         o_wr_addr <= i_load_addr;
         o_wr_data <= i_load_data;
      end
   end

   assign o_imem_wr_en = (state == WRITE) && (target_q == core_cfg_pkg::IMEM);
   assign o_reg_wr_en  = (state == WRITE) && (target_q == core_cfg_pkg::REGS);
   assign o_load_ack   = (state == WAIT_RELEASE);

   // Ack only answers a request that was up at the previous edge.
   a_ack_after_req : assert property (
      @(posedge i_clock) disable iff (i_reset)
      $rose(o_load_ack) |-> $past(i_load_req)
   );

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ns

module register_file
(
   input  logic                   i_clock,
   input  logic                   i_reset,
   input  core_cfg_pkg::reg_idx_t i_rs,
   input  core_cfg_pkg::reg_idx_t i_rt,
   input  logic                   i_load_en,
   input  core_cfg_pkg::reg_idx_t i_load_idx,
   input  core_cfg_pkg::word_t    i_load_data,
   input  logic                   i_wb_en,
   input  core_cfg_pkg::reg_idx_t i_wb_idx,
   input  core_cfg_pkg::word_t    i_wb_data,
   output core_cfg_pkg::word_t    o_rs_data,
   output core_cfg_pkg::word_t    o_rt_data
);

   localparam int NUM_REGS = 2 ** core_cfg_pkg::REG_IDX_W;

   core_cfg_pkg::word_t regs [NUM_REGS];

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (i_load_en && (i_load_idx != '0))
            regs[i_load_idx] <= i_load_data;
         if (i_wb_en && (i_wb_idx != '0))
            regs[i_wb_idx] <= i_wb_data;  // Register 0 never changes.
      end
   end

   assign o_rs_data = regs[i_rs];
   assign o_rt_data = regs[i_rt];

   // The loader only runs while the core is stopped.
   a_no_port_clash : assert property (
      @(posedge i_clock) disable iff (i_reset)
      !(i_load_en && i_wb_en)
   );

endmodule
